// ==== hdl/rob_pkg.sv ====
// Shared definitions for the reorder buffer
//   Default slot count and payload widths
//   Width typedefs for data, meta-data and the ready-entry count
//   State encoding of the valid-bank init sweep

package rob_pkg;

    // ====================================================================
    // Default sizes
    // ====================================================================

    // Number of ring slots, which must be a power of two
    localparam int ROB_ENTRIES = 32;

    // Payload written by index when the result arrives
    localparam int DATA_BITS = 64;

    // Side information stored at allocation time
    localparam int META_BITS = 8;

    // ====================================================================
    // Types
    // ====================================================================

    typedef logic [DATA_BITS-1:0] t_rob_data;
    typedef logic [META_BITS-1:0] t_rob_meta;

    // Ready count only has to stay a little ahead of the consumer,
    // so three bits are plenty
    typedef logic [2:0] t_valid_cnt;

    // The valid banks clear themselves before any data may be written
    typedef enum logic
    {
        SWEEP,
        READY
    } t_sweep_state;

endpackage

// ==== hdl/rob_ram.sv ====
// Simple dual-port RAM for the reorder buffer payloads
//   Write port registered once before the array is updated
//   Read address register and one output register stage

`timescale 1ns/100ps

module rob_ram
#(
    parameter int N_ENTRIES = rob_pkg::ROB_ENTRIES,
    parameter int WIDTH     = rob_pkg::DATA_BITS
)
(
    input  logic                         clk,

    input  logic                         wen,
    input  logic [$clog2(N_ENTRIES)-1:0] waddr,
    input  logic [WIDTH-1:0]             wdata,

    input  logic [$clog2(N_ENTRIES)-1:0] raddr,
    output logic [WIDTH-1:0]             rdata
);

    localparam int IDX_BITS = $clog2(N_ENTRIES);

    logic [WIDTH-1:0]    mem [N_ENTRIES];

    logic                wen_q;
    logic [IDX_BITS-1:0] waddr_q;
    logic [WIDTH-1:0]    wdata_q;
    logic [IDX_BITS-1:0] raddr_q;

    // ====================================================================
    // Write path
    // ====================================================================

    // The write lands in the array one clock after it is presented,
    // so its data can be read two cycles later
    always_ff @(posedge clk)
    begin
        wen_q   <= wen;
        waddr_q <= waddr;
        wdata_q <= wdata;
    end

    always_ff @(posedge clk)
    begin
        if (wen_q)
        begin
            mem[waddr_q] <= wdata_q;
        end
    end

    // ====================================================================
    // Read path
    // ====================================================================

    // Address register followed by an output register, two cycles in all
    always_ff @(posedge clk)
    begin
        raddr_q <= raddr;
        rdata   <= mem[raddr_q];
    end

endmodule

// ==== hdl/rob_valid_bits.sv ====
// Valid-bit store of the reorder buffer
//   Two single-write-port banks indexed by the low bit of the slot index
//   Init sweep that clears every row after reset
//   Registered scan reads with a bypass for same-cycle writes

`timescale 1ns/100ps

module rob_valid_bits
#(
    parameter int N_ENTRIES = rob_pkg::ROB_ENTRIES
)
(
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         enq_en,
    input  logic [$clog2(N_ENTRIES)-1:0] enq_idx,
    input  logic                         wtag,

    input  logic [$clog2(N_ENTRIES)-2:0] scan_idx0,
    input  logic [$clog2(N_ENTRIES)-2:0] scan_idx1,
    input  logic                         scan_tgt,

    output logic [1:0]                   bank_set,
    output logic                         banks_rdy
);

    localparam int IDX_BITS = $clog2(N_ENTRIES);
    localparam int N_ROWS   = N_ENTRIES / 2;

    typedef logic [IDX_BITS-2:0] t_half_idx;

    rob_pkg::t_sweep_state state;
    t_half_idx             sweep_row;
    t_half_idx             enq_row;
    t_half_idx             scan_row [2];

    // Upper index bits pick the row, the low bit picks the bank
    assign enq_row     = enq_idx[IDX_BITS-1:1];
    assign scan_row[0] = scan_idx0;
    assign scan_row[1] = scan_idx1;

    // ====================================================================
    // Init sweep
    // ====================================================================

    // Both banks are cleared in parallel, one row per cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= rob_pkg::SWEEP;
            sweep_row <= '0;
        end
        else if (state == rob_pkg::SWEEP)
        begin
            sweep_row <= sweep_row + 1'b1;
            if (sweep_row == t_half_idx'(N_ROWS - 1))
            begin
                state <= rob_pkg::READY;
            end
        end
    end

    assign banks_rdy = (state == rob_pkg::READY);

    // ====================================================================
    // Banks
    // ====================================================================

    for (genvar p = 0; p < 2; p++)
    begin : g_bank
        logic      bits [N_ROWS];
        logic      enq_wen;
        logic      wen;
        t_half_idx waddr;
        logic      wdata;
        logic      value_q;
        logic      bypass_q;

        assign enq_wen = enq_en && (enq_idx[0] == 1'(p));

        // The sweep owns the write port until it has finished
        always_comb
        begin
            if (state == rob_pkg::SWEEP)
            begin
                wen   = 1'b1;
                waddr = sweep_row;
                wdata = 1'b0;
            end
            else
            begin
                wen   = enq_wen;
                waddr = enq_row;
                wdata = wtag;
            end
        end

        always_ff @(posedge clk)
        begin
            if (wen)
            begin
                bits[waddr] <= wdata;
            end
        end

        // A write to the row being scanned is not visible in the array read
        // of the same edge, so it is flagged alongside the read value
        always_ff @(posedge clk)
        begin
            value_q  <= bits[scan_row[p]];
            bypass_q <= enq_wen && (enq_row == scan_row[p]);
        end

        assign bank_set[p] = (value_q == scan_tgt) || bypass_q;
    end

    // Allocation is held off by not_full until the sweep ends, so no data
    // can exist for a write to collide with the clearing
    sweep_write_a: assert property (@(posedge clk) disable iff (reset)
        (state == rob_pkg::SWEEP) |-> !enq_en)
        else $error("rob_valid_bits: data write during init sweep");

endmodule

// ==== hdl/rob_ring_ctrl.sv ====
// Ring control of the reorder buffer
//   Newest and oldest pointers with the early full threshold
//   Valid tag that flips on every trip of oldest around the ring
//   Two-bank scan for data-ready entries and the ready count

`timescale 1ns/100ps

module rob_ring_ctrl
#(
    parameter int N_ENTRIES           = rob_pkg::ROB_ENTRIES,
    parameter int MIN_FREE_SLOTS      = 1,
    parameter int MAX_ALLOC_PER_CYCLE = 2
)
(
    input  logic                               clk,
    input  logic                               reset,

    input  logic [$clog2(MAX_ALLOC_PER_CYCLE):0] alloc,
    input  logic                               enq_en,
    input  logic [$clog2(N_ENTRIES)-1:0]       enq_idx,
    input  logic                               deq_en,

    input  logic                               banks_rdy,
    input  logic [1:0]                         bank_set,

    output logic                               not_full,
    output logic                               not_empty,
    output logic [$clog2(N_ENTRIES)-1:0]       newest,
    output logic [$clog2(N_ENTRIES)-1:0]       oldest,

    output logic [$clog2(N_ENTRIES)-2:0]       scan_idx0,
    output logic [$clog2(N_ENTRIES)-2:0]       scan_idx1,
    output logic                               scan_tgt,
    output logic                               wtag
);

    localparam int IDX_BITS = $clog2(N_ENTRIES);

    typedef logic [IDX_BITS-1:0] t_idx;

    // Wide enough for N_ENTRIES plus the full threshold terms
    typedef logic [IDX_BITS+1:0] t_count;

    t_idx   used_idx;
    t_count in_use;
    logic   valid_tag;

    logic                scan_bank;
    logic                scan_hit;
    rob_pkg::t_valid_cnt num_valid;

    // ====================================================================
    // Ring pointers
    // ====================================================================

    // Slots between oldest and newest are outstanding. One slot always stays
    // empty, so newest equal to oldest means an empty ring
    assign used_idx = newest - oldest;
    assign in_use   = t_count'(used_idx);

    // Report full early, so that even a widest allocation still leaves
    // MIN_FREE_SLOTS slots free behind it
    assign not_full = banks_rdy &&
        ((in_use + t_count'(MAX_ALLOC_PER_CYCLE) + t_count'(MIN_FREE_SLOTS))
         <= t_count'(N_ENTRIES));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            newest <= '0;
            oldest <= '0;
        end
        else
        begin
            newest <= newest + t_idx'(alloc);
            oldest <= oldest + t_idx'(deq_en);
        end
    end

    // ====================================================================
    // Valid tag
    // ====================================================================

    // The valid banks start at zero, so the first trip marks data with a one.
    // Each later trip inverts the meaning, which avoids a second write port
    // for clearing bits on dequeue
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_tag <= 1'b1;
        end
        else if (deq_en && (&oldest))
        begin
            valid_tag <= ~valid_tag;
        end
    end

    // Indices below oldest already belong to the next trip
    assign wtag = (enq_idx >= oldest) ? valid_tag : ~valid_tag;

    // ====================================================================
    // Scan for ready entries
    // ====================================================================

    // The banks are read in turn so each bank has a cycle to return its
    // registered value before it is tested again
    assign scan_hit = banks_rdy && bank_set[scan_bank] &&
                      (num_valid != rob_pkg::t_valid_cnt'(7));

    always_ff @(posedge clk)
    begin
        if (reset || !banks_rdy)
        begin
            scan_idx0 <= '0;
            scan_idx1 <= '0;
            scan_bank <= 1'b0;
            scan_tgt  <= 1'b1;
        end
        else if (scan_hit)
        begin
            if (scan_bank)
            begin
                scan_idx1 <= scan_idx1 + 1'b1;
                // Bank 1 holds the last slot of the ring, so its wrap ends a trip
                if (&scan_idx1)
                begin
                    scan_tgt <= ~scan_tgt;
                end
            end
            else
            begin
                scan_idx0 <= scan_idx0 + 1'b1;
            end
            scan_bank <= ~scan_bank;
        end
    end

    // Count of oldest entries whose data is known to be present
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            num_valid <= '0;
        end
        else
        begin
            num_valid <= num_valid - rob_pkg::t_valid_cnt'(deq_en) +
                         rob_pkg::t_valid_cnt'(scan_hit);
        end
    end

    assign not_empty = (num_valid != '0);

    // ====================================================================
    // Assertions
    // ====================================================================

    // The reserved gap in front of oldest must survive every allocation
    alloc_gap_a: assert property (@(posedge clk) disable iff (reset)
        (alloc != '0) |-> ((in_use + t_count'(alloc)) < t_count'(N_ENTRIES)))
        else $error("rob_ring_ctrl: allocation reached oldest");

    deq_empty_a: assert property (@(posedge clk) disable iff (reset)
        deq_en |-> not_empty)
        else $error("rob_ring_ctrl: dequeue while empty");

    // Data may only be written for a slot that is allocated and not yet released
    enq_slot_a: assert property (@(posedge clk) disable iff (reset)
        enq_en |-> (t_idx'(enq_idx - oldest) < used_idx))
        else $error("rob_ring_ctrl: data for a slot that is not outstanding");

    pow2_a: assert property (@(posedge clk)
        (N_ENTRIES & (N_ENTRIES - 1)) == 0)
        else $error("rob_ring_ctrl: N_ENTRIES must be a power of two");

endmodule

// ==== hdl/rob_top.sv ====
// Reorder buffer top level
//   Ring control, the two valid-bit banks and the payload RAMs
//   Meta-data is stored on allocation and data on arrival, both read at oldest

`timescale 1ns/100ps

module rob_top
#(
    parameter int N_ENTRIES           = rob_pkg::ROB_ENTRIES,
    parameter int MIN_FREE_SLOTS      = 1,
    parameter int MAX_ALLOC_PER_CYCLE = 2
)
(
    input  logic                                 clk,
    input  logic                                 reset,

    // Allocation of one or more sequential slots
    input  logic [$clog2(MAX_ALLOC_PER_CYCLE):0] alloc,
    input  rob_pkg::t_rob_meta                   alloc_meta,
    output logic                                 not_full,
    output logic [$clog2(N_ENTRIES)-1:0]         alloc_idx,

    // Out-of-order data arrival, always accepted
    input  logic                                 enq_en,
    input  logic [$clog2(N_ENTRIES)-1:0]         enq_idx,
    input  rob_pkg::t_rob_data                   enq_data,

    // In-order release, payload valid two cycles after deq_en
    input  logic                                 deq_en,
    output logic                                 not_empty,
    output rob_pkg::t_rob_data                   first_data,
    output rob_pkg::t_rob_meta                   first_meta
);

    localparam int IDX_BITS = $clog2(N_ENTRIES);

    logic [IDX_BITS-1:0] newest;
    logic [IDX_BITS-1:0] oldest;
    logic [IDX_BITS-2:0] scan_idx0;
    logic [IDX_BITS-2:0] scan_idx1;
    logic                scan_tgt;
    logic                wtag;
    logic [1:0]          bank_set;
    logic                banks_rdy;
    logic                meta_wen;

    // The first slot of an allocation is the handle the requester writes to
    assign alloc_idx = newest;

    // The meta RAM has one write port, so a multi-slot allocation records
    // alloc_meta in its first slot only
    assign meta_wen = (alloc != '0);

    // ====================================================================
    // Control and valid tracking
    // ====================================================================

    rob_ring_ctrl #(
        .N_ENTRIES           (N_ENTRIES),
        .MIN_FREE_SLOTS      (MIN_FREE_SLOTS),
        .MAX_ALLOC_PER_CYCLE (MAX_ALLOC_PER_CYCLE)
    ) rob_ring_ctrl_i (
        .clk       (clk),
        .reset     (reset),
        .alloc     (alloc),
        .enq_en    (enq_en),
        .enq_idx   (enq_idx),
        .deq_en    (deq_en),
        .banks_rdy (banks_rdy),
        .bank_set  (bank_set),
        .not_full  (not_full),
        .not_empty (not_empty),
        .newest    (newest),
        .oldest    (oldest),
        .scan_idx0 (scan_idx0),
        .scan_idx1 (scan_idx1),
        .scan_tgt  (scan_tgt),
        .wtag      (wtag)
    );

    rob_valid_bits #(
        .N_ENTRIES (N_ENTRIES)
    ) rob_valid_bits_i (
        .clk       (clk),
        .reset     (reset),
        .enq_en    (enq_en),
        .enq_idx   (enq_idx),
        .wtag      (wtag),
        .scan_idx0 (scan_idx0),
        .scan_idx1 (scan_idx1),
        .scan_tgt  (scan_tgt),
        .bank_set  (bank_set),
        .banks_rdy (banks_rdy)
    );

    // ====================================================================
    // Payload storage
    // ====================================================================

    rob_ram #(
        .N_ENTRIES (N_ENTRIES),
        .WIDTH     (rob_pkg::DATA_BITS)
    ) data_ram_i (
        .clk   (clk),
        .wen   (enq_en),
        .waddr (enq_idx),
        .wdata (enq_data),
        .raddr (oldest),
        .rdata (first_data)
    );

    rob_ram #(
        .N_ENTRIES (N_ENTRIES),
        .WIDTH     (rob_pkg::META_BITS)
    ) meta_ram_i (
        .clk   (clk),
        .wen   (meta_wen),
        .waddr (newest),
        .wdata (alloc_meta),
        .raddr (oldest),
        .rdata (first_meta)
    );

endmodule

// ==== tb/rob_tb.sv ====
// Self-checking testbench for the reorder buffer
//   Reads test records from the tests file and runs them one after another
//   Allocates slots, returns data in a permuted order and drains in order
//   Keeps a reference queue of expected (data, meta) pairs in allocation order
//   Watchdog bounds the run by the number of entries in the file

`timescale 1ns/100ps

module rob_tb;

    localparam int N_ENTRIES = rob_pkg::ROB_ENTRIES;
    localparam int IDX_BITS  = $clog2(N_ENTRIES);
    localparam int MAX_TESTS = 16;

    typedef logic [IDX_BITS-1:0] t_idx;

    logic                clk;
    logic                reset;
    logic [1:0]          alloc;
    rob_pkg::t_rob_meta  alloc_meta;
    logic                not_full;
    t_idx                alloc_idx;
    logic                enq_en;
    t_idx                enq_idx;
    rob_pkg::t_rob_data  enq_data;
    logic                deq_en;
    logic                not_empty;
    rob_pkg::t_rob_data  first_data;
    rob_pkg::t_rob_meta  first_meta;

    // Test records as read from the file
    int          num_tests;
    int          t_id     [MAX_TESTS];
    int          t_n      [MAX_TESTS];
    int          t_width  [MAX_TESTS];
    int          t_hold   [MAX_TESTS];
    int          t_stall  [MAX_TESTS];
    int          t_full   [MAX_TESTS];
    int          t_plen   [MAX_TESTS];
    int          t_perm   [MAX_TESTS][8];
    logic [7:0]  t_mbase  [MAX_TESTS];
    logic [31:0] t_dbase  [MAX_TESTS];

    // Reference model of outstanding entries, oldest at the front
    rob_pkg::t_rob_data exp_data_q [$];
    rob_pkg::t_rob_meta exp_meta_q [$];
    logic               exp_mchk_q [$];

    int   err_cnt = 0;
    int   issued_cnt;
    int   deq_cnt;
    int   out_cnt;
    logic saw_full;
    t_idx next_slot = '0;
    logic [1:0] deq_pipe = '0;

    rob_top #(
        .N_ENTRIES           (N_ENTRIES),
        .MIN_FREE_SLOTS      (1),
        .MAX_ALLOC_PER_CYCLE (2)
    ) rob_top_i (
        .clk        (clk),
        .reset      (reset),
        .alloc      (alloc),
        .alloc_meta (alloc_meta),
        .not_full   (not_full),
        .alloc_idx  (alloc_idx),
        .enq_en     (enq_en),
        .enq_idx    (enq_idx),
        .enq_data   (enq_data),
        .deq_en     (deq_en),
        .not_empty  (not_empty),
        .first_data (first_data),
        .first_meta (first_meta)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    // ====================================================================
    // Helpers
    // ====================================================================

    task automatic check_value(input logic [63:0] expected, input logic [63:0] actual,
                               input string msg);
        if (expected !== actual)
        begin
            $display("ERROR: t=%0t %s: expected %h, got %h", $time, msg, expected, actual);
            err_cnt++;
        end
    endtask

    // Payloads are derived from the record bases and the entry number
    function automatic rob_pkg::t_rob_data data_of(input int k, input int e);
        return {t_dbase[k], 32'(e)};
    endfunction

    function automatic rob_pkg::t_rob_meta meta_of(input int k, input int e);
        return t_mbase[k] + 8'(e);
    endfunction

    // Output pairs leave two cycles after the dequeue was sampled
    always @(posedge clk)
    begin
        if (deq_pipe[1])
        begin
            if (exp_data_q.size() == 0)
            begin
                $display("An output appeared with no entry outstanding at t=%0t", $time);
                err_cnt++;
            end
            else
            begin
                check_value(64'(exp_data_q.pop_front()), 64'(first_data), "first_data");
                if (exp_mchk_q.pop_front())
                begin
                    check_value(64'(exp_meta_q[0]), 64'(first_meta), "first_meta");
                end
                void'(exp_meta_q.pop_front());
            end
            out_cnt++;
        end
        deq_pipe <= {deq_pipe[0], deq_en};
    end

    // ====================================================================
    // One test
    // ====================================================================

    task automatic run_test(input int k);
        int   n;
        t_idx base_slot;
        n         = t_n[k];
        base_slot = next_slot;
        issued_cnt = 0;
        deq_cnt    = 0;
        out_cnt    = 0;
        saw_full   = 1'b0;
        fork
            begin : alloc_proc
                int e;
                int w;
                e = 0;
                while (e < n)
                begin
                    @(posedge clk);
                    if (not_full)
                    begin
                        w = (t_width[k] == 2 && n - e >= 2) ? 2 : 1;
                        check_value(64'(next_slot), 64'(alloc_idx), "alloc_idx");
                        alloc      <= 2'(w);
                        alloc_meta <= meta_of(k, e);
                        // Only the first slot of a pair has its meta stored
                        for (int j = 0; j < w; j++)
                        begin
                            exp_data_q.push_back(data_of(k, e + j));
                            exp_meta_q.push_back(meta_of(k, e + j));
                            exp_mchk_q.push_back(j == 0);
                        end
                        @(posedge clk);
                        alloc      <= '0;
                        issued_cnt += w;
                        e          += w;
                        next_slot  = next_slot + t_idx'(w);
                    end
                    else
                    begin
                        saw_full = 1'b1;
                    end
                end
            end
            begin : enq_proc
                int base;
                int csize;
                int e;
                base = 0;
                while (base < n)
                begin
                    csize = (n - base < t_plen[k]) ? n - base : t_plen[k];
                    while (issued_cnt < base + csize)
                    begin
                        @(posedge clk);
                    end
                    for (int j = 0; j < t_plen[k]; j++)
                    begin
                        if (t_perm[k][j] < csize)
                        begin
                            e = base + t_perm[k][j];
                            @(posedge clk);
                            // Younger data alone must never make the head ready
                            if (e == 0)
                            begin
                                check_value(64'(0), 64'(not_empty), "not_empty before head data");
                            end
                            enq_en   <= 1'b1;
                            enq_idx  <= base_slot + t_idx'(e);
                            enq_data <= data_of(k, e);
                        end
                    end
                    @(posedge clk);
                    enq_en <= 1'b0;
                    base += csize;
                end
            end
            begin : deq_proc
                repeat (t_hold[k]) @(posedge clk);
                while (deq_cnt < n)
                begin
                    @(posedge clk);
                    if (not_empty && int'($urandom % 100) >= t_stall[k])
                    begin
                        deq_en <= 1'b1;
                        deq_cnt++;
                        // not_empty is stale for one cycle after a dequeue
                        @(posedge clk);
                        deq_en <= 1'b0;
                    end
                end
                repeat (4) @(posedge clk);
            end
        join
        // Every allocated entry has left, so no further entry may be reported ready
        check_value(64'(0), 64'(not_empty), "not_empty after drain");
        if (t_full[k] != 0)
        begin
            check_value(64'(1), 64'(saw_full), "not_full drop");
        end
    endtask

    // ====================================================================
    // Main sequence
    // ====================================================================

    initial
    begin
        int    fd;
        int    nf;
        int    total;
        int    cycles;
        int    fails;
        int    err_before;
        int    v [15];
        string line;
        void'($urandom(24));
        reset      = 1'b1;
        alloc      = '0;
        alloc_meta = '0;
        enq_en     = 1'b0;
        enq_idx    = '0;
        enq_data   = '0;
        deq_en     = 1'b0;
        num_tests  = 0;
        total      = 0;
        fails      = 0;

        fd = $fopen("tb/rob_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the tests file tb/rob_tests.txt");
            err_cnt++;
        end
        else
        begin
            while (!$feof(fd) && num_tests < MAX_TESTS)
            begin
                if ($fgets(line, fd) == 0)
                begin
                    break;
                end
                if (line.len() < 2 || line.substr(0, 0) == "#")
                begin
                    continue;
                end
                nf = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %h %h",
                             v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                             v[9], v[10], v[11], v[12], v[13], v[14],
                             t_mbase[num_tests], t_dbase[num_tests]);
                if (nf == 17)
                begin
                    t_id[num_tests]    = v[0];
                    t_n[num_tests]     = v[1];
                    t_width[num_tests] = v[2];
                    t_hold[num_tests]  = v[3];
                    t_stall[num_tests] = v[4];
                    t_full[num_tests]  = v[5];
                    t_plen[num_tests]  = v[6];
                    for (int j = 0; j < 8; j++)
                    begin
                        t_perm[num_tests][j] = v[7 + j];
                    end
                    total += v[1];
                    num_tests++;
                end
            end
            $fclose(fd);
        end

        fork
            begin : watchdog
                int limit;
                // Per-entry budget on top of reset, the init sweep and a small margin
                limit = total * 40 + 5 + N_ENTRIES / 2 + 10;
                repeat (limit) @(posedge clk);
                $display("Timeout: the run did not finish within %0d cycles", limit);
                $display("Some tests failed");
                $finish;
            end
        join_none

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // The valid banks clear one row per cycle before work is accepted
        cycles = 0;
        while (!not_full)
        begin
            @(posedge clk);
            check_value(64'(0), 64'(not_empty), "not_empty during sweep");
            cycles++;
        end
        check_value(64'(1), 64'(cycles >= N_ENTRIES / 2), "sweep length");

        for (int k = 0; k < num_tests; k++)
        begin
            err_before = err_cnt;
            run_test(k);
            if (err_cnt != err_before)
            begin
                fails++;
            end
            $display("test %0d: %0d entries, %0d outputs, %s", t_id[k], t_n[k], out_cnt,
                     (err_cnt == err_before) ? "ok" : "failed");
        end

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 num_tests, fails, err_cnt);
        if (err_cnt == 0 && num_tests > 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== tb/rob_tests.txt ====
# Reorder buffer test records, one per line
# id count width hold stall_pct expect_full perm_len perm0..perm7 meta_base data_base
#
# count        entries allocated in the test
# width        slots per allocation (1 or 2)
# hold         cycles before the first dequeue may be issued
# stall_pct    chance in percent that a ready dequeue is withheld
# expect_full  1 if not_full must drop during the test
# perm         data arrival order inside each group of perm_len entries
#              (unused positions are padding)
# meta_base    first meta value, hex, incremented per entry
# data_base    upper data word, hex, the lower word is the entry number
#
# Reverse arrival, single allocations
1 8 1 0 0 0 8 7 6 5 4 3 2 1 0 10 a0000001
#
# Permuted arrival with two-wide allocations
2 16 2 0 20 0 8 3 0 6 1 7 2 5 4 20 b0000002
#
# Younger slots first, the head waits for its data
3 12 1 0 50 0 4 3 2 1 0 0 0 0 0 30 c0000003
#
# Full burst held back by the consumer, recovers after dequeues
4 32 2 80 0 1 8 0 1 2 3 4 5 6 7 40 d0000004
#
# Several trips around the ring
5 100 2 0 10 0 8 5 2 7 0 3 6 1 4 50 e0000005
#
# Heavy back-pressure with a group size that leaves a partial group
6 64 1 0 70 0 6 2 5 0 4 1 3 0 0 60 f0000006
#
# Swapped pairs with moderate stalls
7 40 2 0 40 0 2 1 0 0 0 0 0 0 0 70 12340007

// ==== filelist.f ====
hdl/rob_pkg.sv
hdl/rob_ram.sv
hdl/rob_valid_bits.sv
hdl/rob_ring_ctrl.sv
hdl/rob_top.sv
tb/rob_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator from the project root

verilator --binary --timing --assert -f filelist.f --top-module rob_tb -o rob_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/rob_sim > sim.log 2>&1
cat sim.log

grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; } || \
    grep -q "All tests passed" sim.log && echo "Simulation PASSED" || \
    { echo "Simulation ended without a result"; exit 1; }
